// ==== video_defines.svh ====
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// 640x480, negative syncs
`define VGA_H_ACTIVE_640   16'd640
`define VGA_H_FRONT_640    16'd16
`define VGA_H_SYNC_640     16'd96
`define VGA_H_BACK_640     16'd48
`define VGA_V_ACTIVE_640   16'd480
`define VGA_V_FRONT_640    16'd10
`define VGA_V_SYNC_640     16'd2
`define VGA_V_BACK_640     16'd33
`define VGA_HS_POL_640     1'b0
`define VGA_VS_POL_640     1'b0

// 800x600, positive syncs
`define VGA_H_ACTIVE_800   16'd800
`define VGA_H_FRONT_800    16'd40
`define VGA_H_SYNC_800     16'd128
`define VGA_H_BACK_800     16'd88
`define VGA_V_ACTIVE_800   16'd600
`define VGA_V_FRONT_800    16'd1
`define VGA_V_SYNC_800     16'd4
`define VGA_V_BACK_800     16'd23
`define VGA_HS_POL_800     1'b1
`define VGA_VS_POL_800     1'b1

// 1920x1080, positive syncs
`define VGA_H_ACTIVE_1920  16'd1920
`define VGA_H_FRONT_1920   16'd88
`define VGA_H_SYNC_1920    16'd44
`define VGA_H_BACK_1920    16'd148
`define VGA_V_ACTIVE_1920  16'd1080
`define VGA_V_FRONT_1920   16'd4
`define VGA_V_SYNC_1920    16'd5
`define VGA_V_BACK_1920    16'd36
`define VGA_HS_POL_1920    1'b1
`define VGA_VS_POL_1920    1'b1

`define ROM_ADDR_W         5
`define BG_COLOR           16'h0010

`endif

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

   typedef enum logic [1:0] {
      MODE_640X480   = 2'd0,
      MODE_800X600   = 2'd1,
      MODE_1920X1080 = 2'd2
   } video_mode_t;

   // Porch, sync and active lengths of one mode
   typedef struct packed {
      logic [15:0] h_active;
      logic [15:0] h_front;
      logic [15:0] h_sync;
      logic [15:0] h_back;
      logic [15:0] v_active;
      logic [15:0] v_front;
      logic [15:0] v_sync;
      logic [15:0] v_back;
      logic        hs_pol;
      logic        vs_pol;
   } timing_t;

   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } pixel_t;

   typedef struct packed {
      logic [11:0] x;
      logic [11:0] y;
      logic        de;
      logic        hs;
      logic        vs;
   } beam_t;

endpackage

`default_nettype wire

// ==== bus_pkg.sv ====
`default_nettype none
`include "video_defines.svh"

package bus_pkg;

   // Requester side, held until ack
   typedef struct packed {
      logic [`ROM_ADDR_W-1:0] addr;
      logic                   req;
   } rd_req_t;

   typedef struct packed {
      logic [7:0] data;
      logic       ack;
   } rd_rsp_t;

endpackage

`default_nettype wire

// ==== mode_select.sv ====
`default_nettype none

module mode_select import video_pkg::*; (
   input  logic        sys_clk,
   input  logic        reset_n,
   input  logic        key,
   output video_mode_t mode
);

   logic [1:0] key_sync;
   logic       key_prev;
   logic       key_fall;

   assign key_fall = key_prev & ~key_sync[1]; // Release of the key

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         key_sync <= 2'b00;
         key_prev <= 1'b0;
      end else begin
         key_sync <= {key_sync[0], key};
         key_prev <= key_sync[1];
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         mode <= MODE_800X600;
      end else begin
         case (mode)
            MODE_640X480:   if (key_fall) mode <= MODE_800X600;
            MODE_800X600:   if (key_fall) mode <= MODE_1920X1080;
            MODE_1920X1080: if (key_fall) mode <= MODE_640X480;
            default:        mode <= MODE_800X600; // Illegal code
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== video_timing.sv ====
`default_nettype none
`include "video_defines.svh"

module video_timing import video_pkg::*; (
   input  logic        sys_clk,
   input  logic        reset_n,
   input  video_mode_t mode,
   output beam_t       beam
);

   video_mode_t mode_q;
   timing_t     tm;
   logic [15:0] h_total;
   logic [15:0] v_total;
   logic [15:0] hs_start;
   logic [15:0] vs_start;
   logic [11:0] h_cnt;
   logic [11:0] v_cnt;
   logic        h_last;
   logic        v_last;

   always_comb begin
      case (mode_q)
         MODE_640X480: tm = '{`VGA_H_ACTIVE_640, `VGA_H_FRONT_640, `VGA_H_SYNC_640,
                              `VGA_H_BACK_640, `VGA_V_ACTIVE_640, `VGA_V_FRONT_640,
                              `VGA_V_SYNC_640, `VGA_V_BACK_640, `VGA_HS_POL_640,
                              `VGA_VS_POL_640};
         MODE_1920X1080: tm = '{`VGA_H_ACTIVE_1920, `VGA_H_FRONT_1920, `VGA_H_SYNC_1920,
                                `VGA_H_BACK_1920, `VGA_V_ACTIVE_1920, `VGA_V_FRONT_1920,
                                `VGA_V_SYNC_1920, `VGA_V_BACK_1920, `VGA_HS_POL_1920,
                                `VGA_VS_POL_1920};
         default: tm = '{`VGA_H_ACTIVE_800, `VGA_H_FRONT_800, `VGA_H_SYNC_800,
                         `VGA_H_BACK_800, `VGA_V_ACTIVE_800, `VGA_V_FRONT_800,
                         `VGA_V_SYNC_800, `VGA_V_BACK_800, `VGA_HS_POL_800,
                         `VGA_VS_POL_800};
      endcase
   end

   assign h_total  = tm.h_active + tm.h_front + tm.h_sync + tm.h_back;
   assign v_total  = tm.v_active + tm.v_front + tm.v_sync + tm.v_back;
   assign hs_start = tm.h_active + tm.h_front;
   assign vs_start = tm.v_active + tm.v_front;
   assign h_last   = {4'd0, h_cnt} == h_total - 16'd1;
   assign v_last   = {4'd0, v_cnt} == v_total - 16'd1;

   // Reset lands in the vertical front porch so a frame start can be prefetched
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         h_cnt  <= 12'd0;
         v_cnt  <= 12'(`VGA_V_ACTIVE_800);
         mode_q <= MODE_800X600;
      end else if (h_last) begin
         h_cnt <= 12'd0;
         if (v_last) begin
            v_cnt  <= 12'd0;
            mode_q <= mode; // Only at frame wrap
         end else begin
            v_cnt <= v_cnt + 12'd1;
         end
      end else begin
         h_cnt <= h_cnt + 12'd1;
      end
   end

   assign beam.x  = h_cnt;
   assign beam.y  = v_cnt;
   assign beam.de = ({4'd0, h_cnt} < tm.h_active) && ({4'd0, v_cnt} < tm.v_active);
   assign beam.hs = ({4'd0, h_cnt} >= hs_start && {4'd0, h_cnt} < hs_start + tm.h_sync)
                    ? tm.hs_pol : ~tm.hs_pol;
   assign beam.vs = ({4'd0, v_cnt} >= vs_start && {4'd0, v_cnt} < vs_start + tm.v_sync)
                    ? tm.vs_pol : ~tm.vs_pol;

   a_x_in_line: assert property (@(posedge sys_clk) disable iff (!reset_n)
      {4'd0, beam.x} < h_total)
      else $error("x reached line total");

endmodule

`default_nettype wire

// ==== pixel_fetch.sv ====
`default_nettype none
`include "video_defines.svh"

module pixel_fetch import video_pkg::*, bus_pkg::*; (
   input  logic    sys_clk,
   input  logic    reset_n,
   input  beam_t   beam,
   output rd_req_t bus_req,
   input  rd_rsp_t bus_rsp,
   output pixel_t  pixel,
   output beam_t   beam_out
);

   logic                   group_start;
   logic                   line_end;
   logic                   frame_mark;
   logic                   launch;
   logic                   capture;
   logic [`ROM_ADDR_W-1:0] start_addr;
   logic [`ROM_ADDR_W-1:0] addr_q;
   logic                   req_q;
   logic [7:0]             next_byte;
   logic                   nb_valid;
   logic [7:0]             shift_q;
   logic                   pix_bit;

   assign group_start = beam.de && beam.x[2:0] == 3'd0;
   assign line_end    = !beam.de && beam_out.de;              // Active part of line done
   assign frame_mark  = !beam.de && beam.vs != beam_out.vs;   // Any vsync edge
   assign launch      = (group_start || line_end || frame_mark) && !req_q && !bus_rsp.ack;
   assign capture     = req_q && bus_rsp.ack;

   // Row is y mod 4, group is x div 8 mod 8
   always_comb begin
      if (group_start) begin
         start_addr = {beam.y[1:0], beam.x[5:3] + 3'd1};
      end else if (line_end) begin
         start_addr = {beam.y[1:0] + 2'd1, 3'd0}; // Group 0 of the next line
      end else begin
         start_addr = '0;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         req_q    <= 1'b0;
         nb_valid <= 1'b0;
      end else begin
         if (group_start) nb_valid <= 1'b0;
         if (capture) begin
            req_q    <= 1'b0;
            nb_valid <= 1'b1;
         end else if (launch) begin
            req_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (launch) addr_q <= start_addr;
      if (capture) next_byte <= bus_rsp.data;
      if (group_start) begin
         shift_q <= {next_byte[6:0], 1'b0};
      end else begin
         shift_q <= {shift_q[6:0], 1'b0};
      end
   end

   assign bus_req.addr = addr_q;
   assign bus_req.req  = req_q;
   assign pix_bit      = group_start ? next_byte[7] : shift_q[7];

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         pixel    <= '0;
         beam_out <= '0;
      end else begin
         beam_out <= beam;
         if (!beam.de) begin
            pixel <= '0;
         end else if (pix_bit) begin
            pixel <= '1;
         end else begin
            pixel <= pixel_t'(`BG_COLOR);
         end
      end
   end

   a_byte_ready: assert property (@(posedge sys_clk) disable iff (!reset_n)
      group_start |-> nb_valid)
      else $error("pattern byte not fetched in time");

endmodule

`default_nettype wire

// ==== bus_ctrl.sv ====
`default_nettype none
`include "video_defines.svh"

module bus_ctrl import bus_pkg::*; (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  rd_req_t                bus_req,
   output rd_rsp_t                bus_rsp,
   output logic [`ROM_ADDR_W-1:0] rom_addr,
   input  logic [7:0]             rom_data
);

   typedef enum logic [1:0] {IDLE, READ, ACK, RELEASE} state_t;

   state_t state;
   logic   ack_q;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state <= IDLE;
         ack_q <= 1'b0;
      end else begin
         case (state)
            IDLE: if (bus_req.req) state <= READ;
            READ: begin
               ack_q <= 1'b1; // ROM output valid next cycle
               state <= ACK;
            end
            ACK: if (!bus_req.req) begin
               ack_q <= 1'b0;
               state <= RELEASE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == IDLE && bus_req.req) rom_addr <= bus_req.addr;
   end

   assign bus_rsp.data = rom_data; // Held while rom_addr is held
   assign bus_rsp.ack  = ack_q;

   a_idle_no_ack: assert property (@(posedge sys_clk) disable iff (!reset_n)
      state == IDLE && !bus_req.req |-> !bus_rsp.ack)
      else $error("ack high in IDLE");

   a_addr_stable: assert property (@(posedge sys_clk) disable iff (!reset_n)
      bus_req.req && !bus_rsp.ack |=> $stable(bus_req.addr))
      else $error("address moved during request");

endmodule

`default_nettype wire

// ==== pattern_rom.sv ====
`default_nettype none
`include "video_defines.svh"

module pattern_rom (
   input  logic                   sys_clk,
   input  logic [`ROM_ADDR_W-1:0] addr,
   output logic [7:0]             data
);

   logic [7:0] mem [0:(1 << `ROM_ADDR_W)-1];

   initial begin
      $readmemh("pattern_rom.hex", mem);
   end

   always_ff @(posedge sys_clk) begin
      data <= mem[addr];
   end

endmodule

`default_nettype wire

// ==== video_system.sv ====
`default_nettype none
`include "video_defines.svh"

module video_system import video_pkg::*, bus_pkg::*; (
   input  logic        sys_clk,
   input  logic        reset_n,
   input  logic        key,
   output logic        vga_hs,
   output logic        vga_vs,
   output logic        vga_de,
   output pixel_t      vga_rgb,
   output video_mode_t mode
);

   beam_t                  beam;
   beam_t                  beam_d;
   rd_req_t                bus_req;
   rd_rsp_t                bus_rsp;
   logic [`ROM_ADDR_W-1:0] rom_addr;
   logic [7:0]             rom_data;

   mode_select u_mode_select (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .key     (key),
      .mode    (mode)
   );

   video_timing u_video_timing (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .mode    (mode),
      .beam    (beam)
   );

   pixel_fetch u_pixel_fetch (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .beam     (beam),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .pixel    (vga_rgb),
      .beam_out (beam_d)
   );

   bus_ctrl u_bus_ctrl (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .rom_addr (rom_addr),
      .rom_data (rom_data)
   );

   pattern_rom u_pattern_rom (
      .sys_clk (sys_clk),
      .addr    (rom_addr),
      .data    (rom_data)
   );

   // Aligned with vga_rgb
   assign vga_hs = beam_d.hs;
   assign vga_vs = beam_d.vs;
   assign vga_de = beam_d.de;

endmodule

`default_nettype wire

// ==== tb_video_system.sv ====
`default_nettype none
`include "video_defines.svh"

module tb_video_system import video_pkg::*; ();

   localparam int FRAME_640  = 800 * 525;
   localparam int FRAME_800  = 1056 * 628;
   localparam int FRAME_1920 = 2200 * 1125;
   localparam int WATCHDOG_CYCLES = 3 * FRAME_1920 + 1_000_000;
   localparam int LINE_LIMIT = 5000;
   localparam int ADDR_W = `ROM_ADDR_W;
   localparam int SIG_VS = 0;
   localparam int SIG_DE = 1;
   localparam int SIG_HS = 2;

   logic        sys_clk = 1'b0;
   logic        reset_n;
   logic        key;
   logic        vga_hs;
   logic        vga_vs;
   logic        vga_de;
   pixel_t      vga_rgb;
   video_mode_t mode;

   int         errors = 0;
   int         checks = 0;
   int         seed = 32'h260b;
   logic [7:0] rom_model [0:(1 << `ROM_ADDR_W)-1];

   always #5 sys_clk = ~sys_clk;

   video_system u_video_system (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .key     (key),
      .vga_hs  (vga_hs),
      .vga_vs  (vga_vs),
      .vga_de  (vga_de),
      .vga_rgb (vga_rgb),
      .mode    (mode)
   );

   task automatic check_mode(input string name, input video_mode_t exp, input video_mode_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   function automatic logic sample_sig(input int sel);
      case (sel)
         SIG_VS:  return vga_vs;
         SIG_DE:  return vga_de;
         default: return vga_hs;
      endcase
   endfunction

   // Pixel rule from the model ROM
   function automatic pixel_t expected_pixel(input int x, input int y);
      logic [ADDR_W-1:0] addr;
      logic [2:0]        bit_idx;
      addr    = ADDR_W'((y % 4) * 8 + (x / 8) % 8);
      bit_idx = 3'(7 - x % 8);
      if (rom_model[addr][bit_idx]) return pixel_t'(16'hffff);
      return pixel_t'(`BG_COLOR);
   endfunction

   // Returns at the first negedge sample where the signal has just reached level
   task automatic wait_edge(input string what, input int sel, input logic level, input int limit);
      logic prev;
      int   n;
      n    = 0;
      prev = sample_sig(sel);
      @(negedge sys_clk);
      while (!(sample_sig(sel) == level && prev != level) && n < limit) begin
         prev = sample_sig(sel);
         @(negedge sys_clk);
         n++;
      end
      if (!(sample_sig(sel) == level && prev != level)) begin
         errors++;
         $display("ERROR: %s did not switch to %0b within %0d cycles", what, level, limit);
      end
   endtask

   // One line from hs rising edge to the next
   task automatic measure_line(output int period, output int de_cnt, output int hs_low);
      logic prev_hs;
      logic done;
      period = 0;
      de_cnt = 0;
      hs_low = 0;
      wait_edge("vga_hs", SIG_HS, 1'b1, LINE_LIMIT);
      done = 1'b0;
      while (!done) begin
         if (vga_de) de_cnt++;
         if (!vga_hs) hs_low++;
         period++;
         prev_hs = vga_hs;
         @(negedge sys_clk);
         done = (vga_hs && !prev_hs) || period >= LINE_LIMIT;
      end
   endtask

   task automatic press_key();
      @(posedge sys_clk);
      key <= 1'b1;
      repeat (4) @(posedge sys_clk);
      key <= 1'b0;
      repeat (5) @(posedge sys_clk);
      @(negedge sys_clk);
   endtask

   task automatic test_reset();
      int period;
      int de_cnt;
      int hs_low;
      check_mode("reset mode", MODE_800X600, mode);
      check_count("reset de", 0, int'(vga_de));
      check_count("reset hs", 0, int'(vga_hs));
      check_count("reset vs", 0, int'(vga_vs));
      wait_edge("vga_de", SIG_DE, 1'b1, FRAME_800);
      measure_line(period, de_cnt, hs_low);
      check_count("reset line period", 1056, period);
      check_count("reset active pixels", 800, de_cnt);
      check_count("reset hs width", 128, period - hs_low);
   endtask

   task automatic test_mode_cycle();
      int period;
      int de_cnt;
      int hs_low;
      press_key();
      check_mode("mode to 1920", MODE_1920X1080, mode);
      wait_edge("vga_vs", SIG_VS, 1'b1, FRAME_800);
      wait_edge("vga_de", SIG_DE, 1'b1, FRAME_1920);
      measure_line(period, de_cnt, hs_low);
      check_count("1920 line period", 2200, period);
      check_count("1920 active pixels", 1920, de_cnt);
      check_count("1920 hs width", 44, period - hs_low);
      press_key();
      check_mode("mode to 640", MODE_640X480, mode);
      wait_edge("vga_vs", SIG_VS, 1'b1, FRAME_1920);
      wait_edge("vga_de", SIG_DE, 1'b1, FRAME_640);
      measure_line(period, de_cnt, hs_low);
      check_count("640 line period", 800, period);
      check_count("640 active pixels", 640, de_cnt);
      check_count("640 hs low width", 96, hs_low);
      check_count("640 vs idle level", 1, int'(vga_vs));
   endtask

   task automatic test_pattern();
      bit row_pick [int];
      int r;
      int row;
      int n;
      int x;
      int y;
      repeat (8) begin
         r   = $random(seed);
         row = (r & 32'h7fff_ffff) % 480;
         row_pick[row] = 1'b1;
      end
      check_mode("pattern mode", MODE_640X480, mode);
      wait_edge("vga_vs", SIG_VS, 1'b0, FRAME_640);
      wait_edge("vga_de", SIG_DE, 1'b1, FRAME_640); // First pixel of the frame
      n = 0;
      while (n < 640 * 480) begin
         if (vga_de) begin
            x = n % 640;
            y = n / 640;
            if (row_pick.exists(y)) begin
               check_pixel($sformatf("pattern x=%0d y=%0d", x, y), expected_pixel(x, y), vga_rgb);
            end
            n++;
         end else begin
            check_pixel("pattern blanking", pixel_t'(16'h0000), vga_rgb);
         end
         @(negedge sys_clk);
      end
   endtask

   task automatic test_frame();
      int   lines;
      int   de_lines;
      int   n;
      logic p_vs;
      logic p_hs;
      logic p_de;
      logic done;
      wait_edge("vga_vs", SIG_VS, 1'b0, FRAME_640);
      lines    = 0;
      de_lines = 0;
      n        = 0;
      done     = 1'b0;
      p_vs     = vga_vs;
      p_hs     = vga_hs;
      p_de     = vga_de;
      while (!done) begin
         @(negedge sys_clk);
         n++;
         if (p_hs && !vga_hs) lines++; // Active-low hs
         if (!p_de && vga_de) de_lines++;
         done = (p_vs && !vga_vs) || n > FRAME_640 + 1000;
         p_vs = vga_vs;
         p_hs = vga_hs;
         p_de = vga_de;
      end
      check_count("frame active lines", 480, de_lines);
      check_count("frame total lines", 525, lines);
   endtask

   task automatic test_key_hold();
      int changes;
      check_mode("key hold start", MODE_640X480, mode);
      @(posedge sys_clk);
      key <= 1'b1;
      changes = 0;
      repeat (2 * FRAME_640) begin
         @(negedge sys_clk);
         if (mode != MODE_640X480) changes++;
      end
      check_count("key hold mode changes", 0, changes);
      @(posedge sys_clk);
      key <= 1'b0;
      repeat (5) @(posedge sys_clk);
      @(negedge sys_clk);
      check_mode("key release", MODE_800X600, mode);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      $readmemh("pattern_rom.hex", rom_model);
      reset_n = 1'b0;
      key     = 1'b0;
      repeat (2) @(posedge sys_clk);
      reset_n <= 1'b1;
      @(negedge sys_clk);
      test_reset();
      test_mode_cycle();
      test_pattern();
      test_frame();
      test_key_hold();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== pattern_rom.hex ====
// One pattern byte per line, address 0 to 31 (row * 8 + group)
ff
81
c3
e7
00
18
3c
7e
80
40
20
10
08
04
02
01
aa
55
a5
5a
0f
f0
33
cc
11
03
07
0e
1c
38
70
e1

// ==== sim.f ====
+incdir+.
video_pkg.sv
bus_pkg.sv
mode_select.sv
video_timing.sv
pixel_fetch.sv
bus_ctrl.sv
pattern_rom.sv
video_system.sv
tb_video_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the video subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_video_system \
   -o tb_video_system > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/tb_video_system > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status, see sim.log"
   exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "PASS"
   exit 0
else
   echo "FAIL, see sim.log"
   exit 1
fi
